/* include/mem_tile_config.svh */
// Address map, sizes and response field positions of the memory tile
`ifndef MEM_TILE_CONFIG_SVH
`define MEM_TILE_CONFIG_SVH

`define MEM_ADDR_W 16
`define MEM_DATA_W 32

// Local memory map
`define DRAM_BASE 16'h8000
`define DEV_LSB 8
`define CFG_DEV 4'd2
`define CACHE_DEV 4'd1

`define CFG_REGS 8
`define STORE_WORDS 64

// Packed response, data in the low bits
`define RESP_DATA_LSB 0
`define RESP_ADDR_LSB (`RESP_DATA_LSB + `MEM_DATA_W)
`define RESP_OP_BIT (`RESP_ADDR_LSB + `MEM_ADDR_W)

`endif

/* verilog/mem_tile_pkg.sv */
// Width typedefs, opcode constant and response FIFO state type
`include "mem_tile_config.svh"

package mem_tile_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;

  // 0 read, 1 write
  typedef logic mem_op_t;

  localparam mem_op_t OP_WRITE = 1'b1;

  // Opcode, address, data from msb down
  typedef logic [`RESP_OP_BIT:0] mem_resp_t;

  typedef enum logic [1:0]
  {
    FIFO_EMPTY,
    FIFO_ONE,
    FIFO_FULL
  } fifo_state_e;

endpackage

/* verilog/mem_dev_if.sv */
// Command and response bus between the dispatcher and one target device
`timescale 1ns/1ps
`include "mem_tile_config.svh"

interface mem_dev_if;

  // Command, valid/ready
  logic                   cmd_v;
  logic                   cmd_op;
  logic [`MEM_ADDR_W-1:0] cmd_addr;
  logic [`MEM_DATA_W-1:0] cmd_data;
  logic                   cmd_ready;

  // Response, valid/yumi
  logic                   resp_v;
  logic                   resp_op;
  logic [`MEM_ADDR_W-1:0] resp_addr;
  logic [`MEM_DATA_W-1:0] resp_data;
  logic                   resp_yumi;

  modport dispatch (output cmd_v, cmd_op, cmd_addr, cmd_data, resp_yumi,
                    input cmd_ready, resp_v, resp_op, resp_addr, resp_data);

  modport device (input cmd_v, cmd_op, cmd_addr, cmd_data, resp_yumi,
                  output cmd_ready, resp_v, resp_op, resp_addr, resp_data);

endinterface

/* verilog/mem_dispatch.sv */
// Address decoder, command fan-out and fixed-priority response arbiter
`timescale 1ns/1ps
`include "mem_tile_config.svh"

module mem_dispatch
  (input  logic                      cmd_v_i
  , input  mem_tile_pkg::mem_op_t    cmd_op_i
  , input  mem_tile_pkg::mem_addr_t  cmd_addr_i
  , input  mem_tile_pkg::mem_data_t  cmd_data_i
  , output logic                     cmd_ready_o

  , mem_dev_if.dispatch              cfg_o
  , mem_dev_if.dispatch              store_o
  , mem_dev_if.dispatch              loop_o

  , output logic                     push_o
  , output mem_tile_pkg::mem_resp_t  push_data_o
  , input  logic                     can_push_i
  );

  import mem_tile_pkg::*;

  localparam int DEV_W = 4;

  logic             local_cmd;
  logic [DEV_W-1:0] dev_field;
  logic             is_cfg;
  logic             is_store;
  logic             is_loop;
  logic             cmd_fire;
  logic             grant_store;
  logic             grant_cfg;
  logic             grant_loop;

  assign local_cmd = (cmd_addr_i < `DRAM_BASE);
  assign dev_field = cmd_addr_i[`DEV_LSB +: DEV_W];

  // DRAM space and the cache device both land in the store
  assign is_cfg   = local_cmd & (dev_field == `CFG_DEV);
  assign is_store = ~local_cmd | (dev_field == `CACHE_DEV);
  assign is_loop  = ~is_cfg & ~is_store;

  // Every target must be free before any one takes a command
  assign cmd_ready_o = cfg_o.cmd_ready & store_o.cmd_ready & loop_o.cmd_ready;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  assign cfg_o.cmd_v   = cmd_fire & is_cfg;
  assign store_o.cmd_v = cmd_fire & is_store;
  assign loop_o.cmd_v  = cmd_fire & is_loop;

  assign {cfg_o.cmd_op, cfg_o.cmd_addr, cfg_o.cmd_data} = {cmd_op_i, cmd_addr_i, cmd_data_i};
  assign {store_o.cmd_op, store_o.cmd_addr, store_o.cmd_data} =
    {cmd_op_i, cmd_addr_i, cmd_data_i};
  assign {loop_o.cmd_op, loop_o.cmd_addr, loop_o.cmd_data} = {cmd_op_i, cmd_addr_i, cmd_data_i};

  // Store first, then config, then loopback
  assign grant_store = can_push_i & store_o.resp_v;
  assign grant_cfg   = can_push_i & ~store_o.resp_v & cfg_o.resp_v;
  assign grant_loop  = can_push_i & ~store_o.resp_v & ~cfg_o.resp_v & loop_o.resp_v;

  assign store_o.resp_yumi = grant_store;
  assign cfg_o.resp_yumi   = grant_cfg;
  assign loop_o.resp_yumi  = grant_loop;

  assign push_o = grant_store | grant_cfg | grant_loop;

  always_comb
  begin
    if (store_o.resp_v)
      push_data_o = {store_o.resp_op, store_o.resp_addr, store_o.resp_data};
    else if (cfg_o.resp_v)
      push_data_o = {cfg_o.resp_op, cfg_o.resp_addr, cfg_o.resp_data};
    else
      push_data_o = {loop_o.resp_op, loop_o.resp_addr, loop_o.resp_data};
  end

endmodule

/* verilog/cfg_regs.sv */
// Configuration register block target
`timescale 1ns/1ps
`include "mem_tile_config.svh"

module cfg_regs
  (input  logic       clk_i
  , input logic       rst_i
  , mem_dev_if.device bus
  );

  import mem_tile_pkg::*;

  localparam int IDX_W = $clog2(`CFG_REGS);

  mem_data_t        regs_q [`CFG_REGS];
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             resp_v_q;
  mem_op_t          resp_op_q;
  mem_addr_t        resp_addr_q;
  mem_data_t        resp_data_q;

  assign idx    = bus.cmd_addr[2 +: IDX_W];
  assign accept = bus.cmd_v & bus.cmd_ready;

  // One response held at a time
  assign bus.cmd_ready = ~resp_v_q;
  assign bus.resp_v    = resp_v_q;
  assign bus.resp_op   = resp_op_q;
  assign bus.resp_addr = resp_addr_q;
  assign bus.resp_data = resp_data_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (bus.resp_yumi)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      regs_q <= '{default: '0};
    else if (accept && bus.cmd_op == OP_WRITE)
      regs_q[idx] <= bus.cmd_data;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_q   <= bus.cmd_op;
      resp_addr_q <= bus.cmd_addr;
      // Writes answer with zero data
      resp_data_q <= (bus.cmd_op == OP_WRITE) ? '0 : regs_q[idx];
    end
  end

endmodule

/* verilog/local_store.sv */
// Word-addressed local data store target standing in for the cache slice
`timescale 1ns/1ps
`include "mem_tile_config.svh"

module local_store
  (input  logic       clk_i
  , input logic       rst_i
  , mem_dev_if.device bus
  );

  localparam int IDX_W = $clog2(`STORE_WORDS);

  logic [`MEM_DATA_W-1:0] mem_q [`STORE_WORDS];
  logic [IDX_W-1:0]       idx;
  logic                   accept;
  logic                   resp_v_q;
  logic                   resp_op_q;
  logic [`MEM_ADDR_W-1:0] resp_addr_q;
  logic [`MEM_DATA_W-1:0] resp_data_q;

  // Word index, so upper address bits alias
  assign idx    = bus.cmd_addr[2 +: IDX_W];
  assign accept = bus.cmd_v & bus.cmd_ready;

  assign bus.cmd_ready = ~resp_v_q;
  assign bus.resp_v    = resp_v_q;
  assign bus.resp_op   = resp_op_q;
  assign bus.resp_addr = resp_addr_q;
  assign bus.resp_data = resp_data_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (bus.resp_yumi)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (bus.cmd_op)
        mem_q[idx] <= bus.cmd_data;
      resp_op_q   <= bus.cmd_op;
      resp_addr_q <= bus.cmd_addr;
      resp_data_q <= bus.cmd_op ? '0 : mem_q[idx];
    end
  end

endmodule

/* verilog/loopback_dev.sv */
// Loopback target for unmapped local addresses, answers with zero data
`timescale 1ns/1ps

module loopback_dev
  (input  logic       clk_i
  , input logic       rst_i
  , mem_dev_if.device bus
  );

  import mem_tile_pkg::*;

  logic      resp_v_q;
  mem_op_t   resp_op_q;
  mem_addr_t resp_addr_q;

  assign bus.cmd_ready = ~resp_v_q;
  assign bus.resp_v    = resp_v_q;
  assign bus.resp_op   = resp_op_q;
  assign bus.resp_addr = resp_addr_q;
  assign bus.resp_data = '0;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_q <= 1'b0;
    else if (bus.cmd_v & bus.cmd_ready)
      resp_v_q <= 1'b1;
    else if (bus.resp_yumi)
      resp_v_q <= 1'b0;
  end

  // Echo opcode and address only
  always_ff @(posedge clk_i)
  begin
    if (bus.cmd_v & bus.cmd_ready)
    begin
      resp_op_q   <= bus.cmd_op;
      resp_addr_q <= bus.cmd_addr;
    end
  end

endmodule

/* verilog/resp_fifo.sv */
// Two-entry response FIFO with occupancy state machine
`timescale 1ns/1ps

module resp_fifo
  (input  logic                      clk_i
  , input  logic                     rst_i
  , input  logic                     push_i
  , input  mem_tile_pkg::mem_resp_t  push_data_i
  , output logic                     can_push_o
  , output logic                     pop_v_o
  , output mem_tile_pkg::mem_resp_t  pop_data_o
  , input  logic                     pop_ready_i
  );

  import mem_tile_pkg::*;

  fifo_state_e state_q;
  fifo_state_e state_d;
  mem_resp_t   head_q;
  mem_resp_t   tail_q;
  logic        pop;

  assign pop        = pop_v_o & pop_ready_i;
  assign can_push_o = (state_q != FIFO_FULL);
  assign pop_v_o    = (state_q != FIFO_EMPTY);
  assign pop_data_o = head_q;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      FIFO_EMPTY:
        if (push_i)
          state_d = FIFO_ONE;
      FIFO_ONE:
        if (push_i & ~pop)
          state_d = FIFO_FULL;
        else if (~push_i & pop)
          state_d = FIFO_EMPTY;
      FIFO_FULL:
        if (pop)
          state_d = FIFO_ONE;
      default:
        state_d = FIFO_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_q <= FIFO_EMPTY;
    else
      state_q <= state_d;
  end

  // Head is always the oldest entry
  always_ff @(posedge clk_i)
  begin
    if (state_q == FIFO_FULL)
    begin
      if (pop)
        head_q <= tail_q;
    end
    else if (push_i)
    begin
      if (state_q == FIFO_EMPTY || pop)
        head_q <= push_data_i;
      else
        tail_q <= push_data_i;
    end
  end

endmodule

/* verilog/mem_tile.sv */
// Memory tile top level with dispatcher, three targets and response FIFO
`timescale 1ns/1ps
`include "mem_tile_config.svh"

module mem_tile
  (input  logic                      clk_i
  , input  logic                     rst_i

  , input  logic                     cmd_v_i
  , input  mem_tile_pkg::mem_op_t    cmd_op_i
  , input  mem_tile_pkg::mem_addr_t  cmd_addr_i
  , input  mem_tile_pkg::mem_data_t  cmd_data_i
  , output logic                     cmd_ready_o

  , output logic                     resp_v_o
  , output mem_tile_pkg::mem_op_t    resp_op_o
  , output mem_tile_pkg::mem_addr_t  resp_addr_o
  , output mem_tile_pkg::mem_data_t  resp_data_o
  , input  logic                     resp_ready_i
  );

  import mem_tile_pkg::*;

  logic      push;
  mem_resp_t push_data;
  logic      can_push;
  mem_resp_t fifo_data;

  mem_dev_if cfg_bus ();
  mem_dev_if store_bus ();
  mem_dev_if loop_bus ();

  mem_dispatch u_dispatch
    (.cmd_v_i     (cmd_v_i)
    , .cmd_op_i   (cmd_op_i)
    , .cmd_addr_i (cmd_addr_i)
    , .cmd_data_i (cmd_data_i)
    , .cmd_ready_o(cmd_ready_o)
    , .cfg_o      (cfg_bus)
    , .store_o    (store_bus)
    , .loop_o     (loop_bus)
    , .push_o     (push)
    , .push_data_o(push_data)
    , .can_push_i (can_push)
    );

  cfg_regs u_cfg_regs (.clk_i(clk_i), .rst_i(rst_i), .bus(cfg_bus));

  local_store u_local_store (.clk_i(clk_i), .rst_i(rst_i), .bus(store_bus));

  loopback_dev u_loopback (.clk_i(clk_i), .rst_i(rst_i), .bus(loop_bus));

  resp_fifo u_resp_fifo
    (.clk_i       (clk_i)
    , .rst_i      (rst_i)
    , .push_i     (push)
    , .push_data_i(push_data)
    , .can_push_o (can_push)
    , .pop_v_o    (resp_v_o)
    , .pop_data_o (fifo_data)
    , .pop_ready_i(resp_ready_i)
    );

  // Unpack the FIFO head onto the response port
  assign resp_op_o   = fifo_data[`RESP_OP_BIT];
  assign resp_addr_o = fifo_data[`RESP_ADDR_LSB +: `MEM_ADDR_W];
  assign resp_data_o = fifo_data[`RESP_DATA_LSB +: `MEM_DATA_W];

endmodule

/* sim/mem_tile_checker.sv */
// Handshake assertions on the memory tile command and response ports
`timescale 1ns/1ps

module mem_tile_checker
  (input  logic                     clk_i
  , input logic                     rst_i
  , input logic                     cmd_v_i
  , input logic                     cmd_ready_o
  , input logic                     resp_v_o
  , input logic                     resp_ready_i
  , input mem_tile_pkg::mem_op_t    resp_op_o
  , input mem_tile_pkg::mem_addr_t  resp_addr_o
  , input mem_tile_pkg::mem_data_t  resp_data_o
  );

  logic [7:0] pending_q;
  int         assert_fails = 0;

  // Commands accepted but not yet delivered
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pending_q <= '0;
    else
      pending_q <= pending_q + 8'(cmd_v_i & cmd_ready_o) - 8'(resp_v_o & resp_ready_i);
  end

  resp_held_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_op_o)
      && $stable(resp_addr_o) && $stable(resp_data_o))
  else
  begin
    $error("response port changed while stalled");
    assert_fails++;
  end

  resp_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !resp_v_o)
  else
  begin
    $error("response valid right after reset");
    assert_fails++;
  end

  resp_has_command: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o |-> pending_q != 8'd0)
  else
  begin
    $error("response valid with no accepted command");
    assert_fails++;
  end

endmodule

/* sim/mem_tile_tb.sv */
// Testbench for the memory tile with golden-file commands under random response back-pressure
`timescale 1ns/1ps
`include "mem_tile_config.svh"

module mem_tile_tb;

  import mem_tile_pkg::*;

  localparam int          CLK_PERIOD  = 100;
  localparam int          DRIVE_DELAY = 10;
  localparam int          MAX_VECTORS = 64;
  localparam int          FIELDS      = 4;
  localparam int unsigned SEED        = 32'h264a_39f3;

  logic        clk_i;
  logic        rst_i;
  logic        cmd_v_i;
  mem_op_t     cmd_op_i;
  mem_addr_t   cmd_addr_i;
  mem_data_t   cmd_data_i;
  logic        cmd_ready_o;
  logic        resp_v_o;
  mem_op_t     resp_op_o;
  mem_addr_t   resp_addr_o;
  mem_data_t   resp_data_o;
  logic        resp_ready_i;

  logic [31:0] golden_mem [FIELDS*MAX_VECTORS];
  mem_resp_t   expect_q [$];
  int          num_vectors = 0;
  int          num_checked = 0;
  int          mismatch_errors = 0;
  int          other_errors = 0;
  logic        loaded = 1'b0;

  mem_tile u_mem_tile
    (.clk_i        (clk_i)
    , .rst_i       (rst_i)
    , .cmd_v_i     (cmd_v_i)
    , .cmd_op_i    (cmd_op_i)
    , .cmd_addr_i  (cmd_addr_i)
    , .cmd_data_i  (cmd_data_i)
    , .cmd_ready_o (cmd_ready_o)
    , .resp_v_o    (resp_v_o)
    , .resp_op_o   (resp_op_o)
    , .resp_addr_o (resp_addr_o)
    , .resp_data_o (resp_data_o)
    , .resp_ready_i(resp_ready_i)
    );

  bind mem_tile mem_tile_checker u_checker
    (.clk_i        (clk_i)
    , .rst_i       (rst_i)
    , .cmd_v_i     (cmd_v_i)
    , .cmd_ready_o (cmd_ready_o)
    , .resp_v_o    (resp_v_o)
    , .resp_ready_i(resp_ready_i)
    , .resp_op_o   (resp_op_o)
    , .resp_addr_o (resp_addr_o)
    , .resp_data_o (resp_data_o)
    );

  // Unloaded entries stay all ones, which ends the vector list
  task automatic load_vectors();
    int idx;
    for (idx = 0; idx < FIELDS*MAX_VECTORS; idx++)
      golden_mem[idx] = '1;
    $readmemh("sim/mem_tile_golden.txt", golden_mem);
    while (num_vectors < MAX_VECTORS && golden_mem[FIELDS*num_vectors] != 32'hffff_ffff)
      num_vectors++;
  endtask

  // Entered just after a drive point, returns at the next one
  task automatic send_command(input int vec);
    mem_op_t   op;
    mem_addr_t addr;
    mem_data_t rdata;
    op    = golden_mem[FIELDS*vec][0];
    addr  = golden_mem[FIELDS*vec+1][15:0];
    rdata = golden_mem[FIELDS*vec+3];
    cmd_v_i    = 1'b1;
    cmd_op_i   = op;
    cmd_addr_i = addr;
    cmd_data_i = golden_mem[FIELDS*vec+2];
    @(negedge clk_i);
    while (!cmd_ready_o)
      @(negedge clk_i);
    expect_q.push_back({op, addr, rdata});
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic check_response();
    mem_resp_t expected;
    if (expect_q.size() == 0)
    begin
      other_errors++;
      $display("Error at %0t ns: a response came out with no command waiting for it", $time);
    end
    else
    begin
      expected = expect_q.pop_front();
      if (resp_op_o != expected[`RESP_OP_BIT])
      begin
        mismatch_errors++;
        $display("[FAIL] %0t ns: response %0d opcode %0d, expected %0d", $time, num_checked,
                 resp_op_o, expected[`RESP_OP_BIT]);
      end
      if (resp_addr_o != expected[`RESP_ADDR_LSB +: `MEM_ADDR_W])
      begin
        mismatch_errors++;
        $display("[FAIL] %0t ns: response %0d address %h, expected %h", $time, num_checked,
                 resp_addr_o, expected[`RESP_ADDR_LSB +: `MEM_ADDR_W]);
      end
      if (resp_data_o != expected[`RESP_DATA_LSB +: `MEM_DATA_W])
      begin
        mismatch_errors++;
        $display("[FAIL] %0t ns: response %0d data %h, expected %h", $time, num_checked,
                 resp_data_o, expected[`RESP_DATA_LSB +: `MEM_DATA_W]);
      end
      num_checked++;
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // Random back-pressure with ready about three cycles in eight
  initial
  begin
    void'($urandom(SEED));
    resp_ready_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      resp_ready_i = (($urandom % 8) < 3);
    end
  end

  // Sampled mid-cycle away from both edges
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (!rst_i && resp_v_o && resp_ready_i)
        check_response();
    end
  end

  initial
  begin
    rst_i      = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = 1'b0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    if (num_vectors == 0)
    begin
      other_errors++;
      $display("Error: the golden file gave no command vectors");
    end
    for (int i = 0; i < num_vectors; i++)
      send_command(i);
    cmd_v_i = 1'b0;
    while (expect_q.size() != 0)
      @(negedge clk_i);
    // A few idle cycles to catch stray responses
    repeat (4) @(posedge clk_i);
    $display("Checked %0d responses, %0d mismatches, %0d other errors, %0d assertion failures",
             num_checked, mismatch_errors, other_errors, u_mem_tile.u_checker.assert_fails);
    if (mismatch_errors == 0 && other_errors == 0 && u_mem_tile.u_checker.assert_fails == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial
  begin
    wait (loaded);
    repeat (num_vectors * 20 + 100) @(posedge clk_i);
    other_errors++;
    $display("Timeout: run did not finish, %0d responses still missing", expect_q.size());
    $display("Checked %0d responses, %0d mismatches, %0d other errors, %0d assertion failures",
             num_checked, mismatch_errors, other_errors, u_mem_tile.u_checker.assert_fails);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* sim/mem_tile_golden.txt */
// op addr wdata rdata, all hex, one command per line
// rdata is the expected response data of a read and zero for a write
0 0204 00000000 00000000
1 0204 a5a51111 00000000
0 0204 00000000 a5a51111
1 021c deadbeef 00000000
0 021c 00000000 deadbeef
0 0208 00000000 00000000
1 0220 0badf00d 00000000
0 0200 00000000 0badf00d
1 1208 12345678 00000000
0 0208 00000000 12345678
0 020c 00000000 00000000
1 8000 11112222 00000000
0 8000 00000000 11112222
1 80fc 33334444 00000000
0 80fc 00000000 33334444
1 0104 55556666 00000000
0 0104 00000000 55556666
0 8104 00000000 55556666
1 c100 77778888 00000000
0 0100 00000000 77778888
0 01fc 00000000 33334444
1 fffc 5a5a5a5a 00000000
0 81fc 00000000 5a5a5a5a
1 0000 cafef00d 00000000
0 0004 00000000 00000000
0 0304 00000000 00000000
1 7f10 99999999 00000000
0 7f10 00000000 00000000
0 0e00 00000000 00000000
0 00fc 00000000 00000000
1 8010 aaaa0001 00000000
1 0210 aaaa0002 00000000
1 0410 aaaa0003 00000000
0 8010 00000000 aaaa0001
0 0210 00000000 aaaa0002
0 0410 00000000 00000000
0 0110 00000000 aaaa0001
0 0220 00000000 0badf00d

/* mem_tile.f */
+incdir+include
verilog/mem_tile_pkg.sv
verilog/mem_dev_if.sv
verilog/mem_dispatch.sv
verilog/cfg_regs.sv
verilog/local_store.sv
verilog/loopback_dev.sv
verilog/resp_fifo.sv
verilog/mem_tile.sv
sim/mem_tile_checker.sv
sim/mem_tile_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_tile_tb
FILELIST = mem_tile.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove build outputs and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
